//--- list.f
common/evreq_pkg.sv
hw/sync_fifo.sv
req_gen/chunk_cmd_fsm.sv
req_gen/dm_cmd_queue.sv
cmpl/cmpl_tracker.sv
hw/event_req_gen.sv
testbench/event_req_gen_asserts.sv
testbench/tb_event_req_gen.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the event request generator testbench with Verilator.
# The exit status is the simulator's, non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_event_req_gen \
    -f list.f \
    -o sim_tb_event_req_gen
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb_event_req_gen
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0

//--- testbench/tb_event_req_gen.sv
`timescale 1ns/1ps
module tb_event_req_gen;

    localparam int BASE_4KB = 9;
    // three events of 28 chunks at no more than 9 cycles each plus 85 statuses need
    // about 1100 cycles
    localparam int TIMEOUT_CYCLES = 20000;

    logic                        memclk;
    logic                        memresetn;
    logic                        payload_valid_i;
    evreq_pkg::payload_ident_t   payload_ident_i;
    logic                        payload_last_i;
    logic                        payload_has_space_o;
    logic                        done_valid_i;
    logic [12:0]                 done_addr_i;
    logic                        done_ready_o;
    evreq_pkg::dm_cmd_t          dm_cmd_o;
    logic                        dm_cmd_valid_o;
    logic                        dm_cmd_ready_i;
    logic                        dm_stat_valid_i;
    evreq_pkg::dm_stat_t         dm_stat_i;
    evreq_pkg::cmpl_t            cmpl_o;
    logic                        cmpl_valid_o;
    logic                        cmpl_ready_i;
    evreq_pkg::cmd_err_t         cmd_err_o;

    // scoreboard queues and reference state
    evreq_pkg::dm_cmd_t exp_cmds[$];
    evreq_pkg::dm_cmd_t got_cmds[$];
    evreq_pkg::cmpl_t   exp_cmpls[$];
    evreq_pkg::cmpl_t   got_cmpls[$];
    logic [12:0]        pending_addrs[$];
    logic [26:0]        model_hist;
    logic [3:0]         model_sticky;
    int                 done_pulses;
    int                 cycle_count;
    logic [31:0]        lfsr_state;

    event_req_gen #(
        .BASE_ADDRESS_4KB (7'(BASE_4KB)),
        .CMD_DEPTH        (32),
        .DONE_DEPTH       (4),
        .CMPL_DEPTH       (4)
    ) u_dut (.*);

    initial begin
        memclk = 1'b0;
        forever #20 memclk = ~memclk;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge memclk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $fatal(1, "simulation timed out");
    end

    // handshake monitors sample on the rising edge while inputs move on the falling one
    always @(posedge memclk) begin
        if (memresetn) begin
            if (dm_cmd_valid_o && dm_cmd_ready_i) begin
                got_cmds.push_back(dm_cmd_o);
            end
            if (cmpl_valid_o && cmpl_ready_i) begin
                got_cmpls.push_back(cmpl_o);
            end
            if (done_ready_o) begin
                done_pulses++;
            end
        end
    end

    ////////////////////////////////////////
    // random source and reporting
    ////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    task automatic report_err(input string msg);
        $display("ERR at %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "check failed");
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            report_err($sformatf("%s: got %b, expected %b", what, got, want));
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        if (got != want) begin
            report_err($sformatf("%s: got %0d, expected %0d", what, got, want));
        end
    endtask

    task automatic check_cmd(input evreq_pkg::dm_cmd_t got, input evreq_pkg::dm_cmd_t want,
                             input int idx);
        if (got !== want) begin
            report_err($sformatf("command %0d: got %h, expected %h", idx, got, want));
        end
    endtask

    task automatic check_cmpl(input evreq_pkg::cmpl_t got, input evreq_pkg::cmpl_t want,
                              input int idx);
        if (got !== want) begin
            report_err($sformatf("completion %0d: got %h, expected %h", idx, got, want));
        end
    endtask

    task automatic check_err(input evreq_pkg::cmd_err_t got, input evreq_pkg::cmd_err_t want,
                             input string what);
        if (got !== want) begin
            report_err($sformatf("cmd_err_o %s: got %b, expected %b", what, got, want));
        end
    endtask

    ////////////////////////////////////////
    // stimulus and expected values
    ////////////////////////////////////////

    // address is done addr, kB offset, then 10 zero bits
    function automatic evreq_pkg::dm_cmd_t build_cmd(input logic [12:0] addr, input int c,
                                                     input int s);
        evreq_pkg::dm_cmd_t cmd;
        logic [8:0]         kb;
        // base in 4 kB units, chunks 4 kB apart, SURFs 16 kB apart
        kb            = 9'(BASE_4KB * 4 + c * 4 + s * 16);
        cmd           = '0;
        cmd.tag       = (c == 3 && s == 6) ? 4'd1 : 4'd0;
        cmd.addr      = {addr, kb, 10'd0};
        cmd.eof       = 1'b1;
        cmd.type_incr = 1'b1;
        cmd.btt       = 23'd4096;
        return cmd;
    endfunction

    task automatic wait_space();
        while (!payload_has_space_o) begin
            @(negedge memclk);
        end
    endtask

    // 4 chunk numbers x 7 SURFs with space checked only at a chunk number boundary
    task automatic drive_event(input logic [12:0] addr);
        int len;
        int gap;
        done_valid_i = 1'b1;
        done_addr_i  = addr;
        pending_addrs.push_back(addr);
        @(negedge memclk);
        for (int c = 0; c < 4; c++) begin
            wait_space();
            for (int s = 0; s < 7; s++) begin
                exp_cmds.push_back(build_cmd(addr, c, s));
                // at least 3 beats keeps last beats 3 cycles apart
                len = 3 + rand_bits(2);
                gap = rand_bits(2);
                payload_ident_i.chunk = 2'(c);
                payload_ident_i.surf  = 3'(s);
                for (int b = 0; b < len; b++) begin
                    payload_valid_i = 1'b1;
                    payload_last_i  = (b == len - 1);
                    @(negedge memclk);
                end
                payload_valid_i = 1'b0;
                payload_last_i  = 1'b0;
                repeat (gap) @(negedge memclk);
            end
        end
        done_valid_i = 1'b0;
    endtask

    // n statuses with the last one tagged and the expected completion built on the way
    task automatic send_statuses(input int n, input logic noisy);
        evreq_pkg::dm_stat_t st;
        evreq_pkg::cmpl_t    want;
        logic [3:0]          cur;
        logic [3:0]          e;
        for (int i = 0; i < n; i++) begin
            e = '0;
            if (noisy && (rand_bits(2) == 0 || i == 3)) begin
                e = 4'(rand_bits(4));
                // transfer 3 of a noisy event always fails
                if (i == 3) begin
                    e[1] = 1'b1;
                end
            end
            st        = '0;
            st.okay   = !e[3];
            st.slverr = e[2];
            st.decerr = e[1];
            st.interr = e[0];
            st.tag    = (i == n - 1) ? 4'd1 : 4'd0;
            cur       = {!st.okay, st.slverr, st.decerr, st.interr};
            if (st.tag[0]) begin
                want = '0;
                // no pending event gives a zero address
                if (pending_addrs.size() > 0) begin
                    want.done_addr = pending_addrs.pop_front();
                end
                want.err_last   = |cur;
                want.err_hist   = model_hist;
                want.sticky_err = model_sticky | cur;
                exp_cmpls.push_back(want);
                model_sticky = '0;
            end else begin
                model_sticky = model_sticky | cur;
            end
            model_hist      = {|cur, model_hist[26:1]};
            dm_stat_valid_i = 1'b1;
            dm_stat_i       = st;
            @(negedge memclk);
            dm_stat_valid_i = 1'b0;
            repeat (rand_bits(1)) @(negedge memclk);
        end
    endtask

    task automatic expect_cmds();
        evreq_pkg::dm_cmd_t got;
        evreq_pkg::dm_cmd_t want;
        int                 idx;
        idx = 0;
        while (exp_cmds.size() > 0) begin
            while (got_cmds.size() == 0) begin
                @(negedge memclk);
            end
            got  = got_cmds.pop_front();
            want = exp_cmds.pop_front();
            check_cmd(got, want, idx);
            idx++;
        end
    endtask

    task automatic expect_cmpls();
        evreq_pkg::cmpl_t got;
        evreq_pkg::cmpl_t want;
        int               idx;
        idx = 0;
        while (exp_cmpls.size() > 0) begin
            while (got_cmpls.size() == 0) begin
                @(negedge memclk);
            end
            got  = got_cmpls.pop_front();
            want = exp_cmpls.pop_front();
            check_cmpl(got, want, idx);
            idx++;
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic reset_state_test();
        check_bit(payload_has_space_o, 1'b0, "payload_has_space_o after reset");
        check_bit(dm_cmd_valid_o, 1'b0, "dm_cmd_valid_o after reset");
        check_bit(done_ready_o, 1'b0, "done_ready_o after reset");
        check_bit(cmpl_valid_o, 1'b0, "cmpl_valid_o after reset");
        check_err(cmd_err_o, '0, "after reset");
        done_valid_i = 1'b1;
        done_addr_i  = 13'h0abc;
        @(negedge memclk);
        check_bit(payload_has_space_o, 1'b1, "payload_has_space_o with a done address");
        done_valid_i = 1'b0;
        @(negedge memclk);
        check_bit(payload_has_space_o, 1'b0, "payload_has_space_o without done address");
    endtask

    task automatic full_event_test();
        int pulses_before;
        pulses_before = done_pulses;
        drive_event(13'(rand_bits(13)));
        expect_cmds();
        repeat (4) @(negedge memclk);
        check_count(got_cmds.size(), 0, "extra commands after the event");
        check_count(done_pulses - pulses_before, 1, "done_ready_o pulses per event");
        check_err(cmd_err_o, '0, "after a full event");
    endtask

    task automatic cmd_backpressure_test();
        dm_cmd_ready_i = 1'b0;
        drive_event(13'(rand_bits(13)));
        repeat (3) @(negedge memclk);
        check_bit(dm_cmd_valid_o, 1'b1, "dm_cmd_valid_o with queued commands");
        // stalled head must still be the first command of the event
        check_cmd(dm_cmd_o, exp_cmds[0], 0);
        dm_cmd_ready_i = 1'b1;
        expect_cmds();
        check_err(cmd_err_o, '0, "after command back-pressure");
    endtask

    // the two events from the tests above are still pending
    task automatic status_cmpl_test();
        send_statuses(28, 1'b1);
        expect_cmpls();
        // a clean second event must come back with zero sticky errors
        send_statuses(28, 1'b0);
        expect_cmpls();
        check_err(cmd_err_o, '0, "after two completions");
    endtask

    task automatic underflow_hold_test();
        evreq_pkg::cmd_err_t want_err;
        want_err                = '0;
        want_err.done_underflow = 1'b1;
        cmpl_ready_i = 1'b0;
        send_statuses(1, 1'b1);
        check_err(cmd_err_o, want_err, "after a last status with no event");
        drive_event(13'(rand_bits(13)));
        expect_cmds();
        send_statuses(28, 1'b1);
        repeat (8) @(negedge memclk);
        check_bit(cmpl_valid_o, 1'b1, "cmpl_valid_o with held completions");
        // held head is the zero address completion from the underflow
        check_cmpl(cmpl_o, exp_cmpls[0], 0);
        cmpl_ready_i = 1'b1;
        expect_cmpls();
        check_err(cmd_err_o, want_err, "underflow bit held");
    endtask

    initial begin
        lfsr_state      = 32'haad0_c6ad;
        memresetn       = 1'b0;
        payload_valid_i = 1'b0;
        payload_ident_i = '0;
        payload_last_i  = 1'b0;
        done_valid_i    = 1'b0;
        done_addr_i     = '0;
        dm_cmd_ready_i  = 1'b1;
        dm_stat_valid_i = 1'b0;
        dm_stat_i       = '0;
        cmpl_ready_i    = 1'b1;
        model_hist      = '0;
        model_sticky    = '0;
        done_pulses     = 0;
        repeat (5) @(negedge memclk);
        memresetn = 1'b1;
        @(negedge memclk);
        reset_state_test();
        full_event_test();
        cmd_backpressure_test();
        status_cmpl_test();
        underflow_hold_test();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- testbench/event_req_gen_asserts.sv
`timescale 1ns/1ps
module event_req_gen_asserts (
    input logic                memclk,
    input logic                memresetn,
    input logic                has_space_i,
    input logic                done_valid_i,
    input logic                done_ready_i,
    input evreq_pkg::dm_cmd_t  dm_cmd_i,
    input logic                dm_cmd_valid_i,
    input logic                dm_cmd_ready_i,
    input evreq_pkg::cmpl_t    cmpl_i,
    input logic                cmpl_valid_i,
    input logic                cmpl_ready_i,
    input evreq_pkg::cmd_err_t cmd_err_i
);

    // one edge into reset the outputs are idle, space only with a done address
    reset_outputs_low: assert property (@(posedge memclk)
        !memresetn |=> (!dm_cmd_valid_i && !cmpl_valid_i && !done_ready_i &&
                        cmd_err_i == '0 && (!has_space_i || done_valid_i)))
        else $error("outputs not idle in reset");

    // stalled command holds its value
    cmd_stable: assert property (@(posedge memclk) disable iff (!memresetn)
        dm_cmd_valid_i && !dm_cmd_ready_i |=> dm_cmd_valid_i && $stable(dm_cmd_i))
        else $error("dm_cmd_o changed while stalled");

    cmpl_stable: assert property (@(posedge memclk) disable iff (!memresetn)
        cmpl_valid_i && !cmpl_ready_i |=> cmpl_valid_i && $stable(cmpl_i))
        else $error("cmpl_o changed while stalled");

    // done address is only consumed while presented
    done_ready_with_valid: assert property (@(posedge memclk) disable iff (!memresetn)
        done_ready_i |-> done_valid_i)
        else $error("done_ready_o without done_valid_i");

endmodule

bind event_req_gen event_req_gen_asserts u_asserts (
    .memclk         (memclk),
    .memresetn      (memresetn),
    .has_space_i    (payload_has_space_o),
    .done_valid_i   (done_valid_i),
    .done_ready_i   (done_ready_o),
    .dm_cmd_i       (dm_cmd_o),
    .dm_cmd_valid_i (dm_cmd_valid_o),
    .dm_cmd_ready_i (dm_cmd_ready_i),
    .cmpl_i         (cmpl_o),
    .cmpl_valid_i   (cmpl_valid_o),
    .cmpl_ready_i   (cmpl_ready_i),
    .cmd_err_i      (cmd_err_o)
);

//--- hw/event_req_gen.sv
`timescale 1ns/1ps
module event_req_gen #(
    parameter logic [6:0] BASE_ADDRESS_4KB = 7'd4,
    parameter int         CMD_DEPTH        = 32,
    parameter int         DONE_DEPTH       = 16,
    parameter int         CMPL_DEPTH       = 16
) (
    input  logic                              memclk,
    input  logic                              memresetn,
    // payload side, strobes and levels only
    input  logic                              payload_valid_i,
    input  evreq_pkg::payload_ident_t         payload_ident_i,
    input  logic                              payload_last_i,
    output logic                              payload_has_space_o,
    // done address stream
    input  logic                              done_valid_i,
    input  logic [evreq_pkg::DONE_ADDR_W-1:0] done_addr_i,
    output logic                              done_ready_o,
    // DataMover command and status
    output evreq_pkg::dm_cmd_t                dm_cmd_o,
    output logic                              dm_cmd_valid_o,
    input  logic                              dm_cmd_ready_i,
    input  logic                              dm_stat_valid_i,
    input  evreq_pkg::dm_stat_t               dm_stat_i,
    // completion stream
    output evreq_pkg::cmpl_t                  cmpl_o,
    output logic                              cmpl_valid_o,
    input  logic                              cmpl_ready_i,
    output evreq_pkg::cmd_err_t               cmd_err_o
);
    logic                     cmd_wr;
    evreq_pkg::dm_cmd_entry_t cmd_entry;
    logic                     final_wr;
    logic                     cmd_ovf;
    logic                     done_ovf;
    logic                     done_unf;
    logic                     cmpl_ovf;
    evreq_pkg::cmd_err_t      cmd_err_q;

    chunk_cmd_fsm #(
        .BASE_ADDRESS_4KB (BASE_ADDRESS_4KB)
    ) u_chunk_cmd_fsm (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .payload_valid_i     (payload_valid_i),
        .payload_ident_i     (payload_ident_i),
        .payload_last_i      (payload_last_i),
        .done_valid_i        (done_valid_i),
        .done_addr_i         (done_addr_i),
        .payload_has_space_o (payload_has_space_o),
        .cmd_wr_o            (cmd_wr),
        .cmd_entry_o         (cmd_entry),
        .final_wr_o          (final_wr)
    );

    dm_cmd_queue #(
        .CMD_DEPTH (CMD_DEPTH)
    ) u_dm_cmd_queue (
        .memclk         (memclk),
        .memresetn      (memresetn),
        .cmd_wr_i       (cmd_wr),
        .cmd_entry_i    (cmd_entry),
        .dm_cmd_ready_i (dm_cmd_ready_i),
        .dm_cmd_o       (dm_cmd_o),
        .dm_cmd_valid_o (dm_cmd_valid_o),
        .overflow_o     (cmd_ovf)
    );

    cmpl_tracker #(
        .DONE_DEPTH (DONE_DEPTH),
        .CMPL_DEPTH (CMPL_DEPTH)
    ) u_cmpl_tracker (
        .memclk           (memclk),
        .memresetn        (memresetn),
        .final_wr_i       (final_wr),
        .done_addr_i      (done_addr_i),
        .dm_stat_valid_i  (dm_stat_valid_i),
        .dm_stat_i        (dm_stat_i),
        .cmpl_ready_i     (cmpl_ready_i),
        .cmpl_o           (cmpl_o),
        .cmpl_valid_o     (cmpl_valid_o),
        .done_overflow_o  (done_ovf),
        .done_underflow_o (done_unf),
        .cmpl_overflow_o  (cmpl_ovf)
    );

    // done address is consumed by the final command write
    assign done_ready_o = final_wr;

    // sticky errors, only reset clears them
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            cmd_err_q <= '0;
        end else begin
            if (cmd_ovf) cmd_err_q.cmd_overflow <= 1'b1;
            if (done_ovf) cmd_err_q.done_overflow <= 1'b1;
            if (cmpl_ovf) cmd_err_q.cmpl_overflow <= 1'b1;
            if (done_unf) cmd_err_q.done_underflow <= 1'b1;
        end
    end

    assign cmd_err_o = cmd_err_q;

endmodule

//--- cmpl/cmpl_tracker.sv
`timescale 1ns/1ps
module cmpl_tracker #(
    parameter int DONE_DEPTH = 16,
    parameter int CMPL_DEPTH = 16
) (
    input  logic                              memclk,
    input  logic                              memresetn,
    input  logic                              final_wr_i,
    input  logic [evreq_pkg::DONE_ADDR_W-1:0] done_addr_i,
    input  logic                              dm_stat_valid_i,
    input  evreq_pkg::dm_stat_t               dm_stat_i,
    input  logic                              cmpl_ready_i,
    output evreq_pkg::cmpl_t                  cmpl_o,
    output logic                              cmpl_valid_o,
    output logic                              done_overflow_o,
    output logic                              done_underflow_o,
    output logic                              cmpl_overflow_o
);
    localparam int HIST_W = evreq_pkg::NUM_SURF_XFERS - 1;

    logic [3:0]                        cur_err;
    logic                              err_any;
    logic                              stat_last;
    logic [3:0]                        sticky_q;
    logic [HIST_W-1:0]                 hist_q;
    logic [evreq_pkg::DONE_ADDR_W-1:0] done_head;
    logic                              done_valid;
    evreq_pkg::cmpl_t                  cmpl_in;

    ////////////////////////////////////////
    // status reduction
    ////////////////////////////////////////

    // status as pure errors, not-okay plus the three error bits
    assign cur_err   = {!dm_stat_i.okay, dm_stat_i.slverr, dm_stat_i.decerr, dm_stat_i.interr};
    assign err_any   = |cur_err;
    // tag bit 0 marks the final transfer of the event
    assign stat_last = dm_stat_valid_i && dm_stat_i.tag[0];

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            sticky_q <= '0;
            hist_q   <= '0;
        end else if (dm_stat_valid_i) begin
            if (dm_stat_i.tag[0]) begin
                sticky_q <= '0;
            end else begin
                sticky_q <= sticky_q | cur_err;
            end
            // 28th transfer rides in err_last, so only 27 kept
            hist_q <= {err_any, hist_q[HIST_W-1:1]};
        end
    end

    ////////////////////////////////////////
    // done address and completion FIFOs
    ////////////////////////////////////////

    // pushed with the final command, popped by the last status
    sync_fifo #(
        .DEPTH (DONE_DEPTH),
        .T     (logic [evreq_pkg::DONE_ADDR_W-1:0])
    ) u_done_fifo (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .wr_i        (final_wr_i),
        .din_i       (done_addr_i),
        .full_o      (),
        .overflow_o  (done_overflow_o),
        .rd_i        (stat_last),
        .dout_o      (done_head),
        .valid_o     (done_valid),
        .underflow_o (done_underflow_o)
    );

    // empty done FIFO gives a zero address, completion still goes out
    assign cmpl_in.done_addr  = done_valid ? done_head : '0;
    assign cmpl_in.err_last   = err_any;
    assign cmpl_in.err_hist   = hist_q;
    assign cmpl_in.sticky_err = sticky_q | cur_err;

    sync_fifo #(
        .DEPTH (CMPL_DEPTH),
        .T     (evreq_pkg::cmpl_t)
    ) u_cmpl_fifo (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .wr_i        (stat_last),
        .din_i       (cmpl_in),
        .full_o      (),
        .overflow_o  (cmpl_overflow_o),
        .rd_i        (cmpl_valid_o && cmpl_ready_i),
        .dout_o      (cmpl_o),
        .valid_o     (cmpl_valid_o),
        .underflow_o ()
    );

endmodule

//--- req_gen/dm_cmd_queue.sv
`timescale 1ns/1ps
module dm_cmd_queue #(
    parameter int CMD_DEPTH = 32
) (
    input  logic                     memclk,
    input  logic                     memresetn,
    input  logic                     cmd_wr_i,
    input  evreq_pkg::dm_cmd_entry_t cmd_entry_i,
    input  logic                     dm_cmd_ready_i,
    output evreq_pkg::dm_cmd_t       dm_cmd_o,
    output logic                     dm_cmd_valid_o,
    output logic                     overflow_o
);
    evreq_pkg::dm_cmd_entry_t head;

    // compact entries, 23 bits instead of 72
    sync_fifo #(
        .DEPTH (CMD_DEPTH),
        .T     (evreq_pkg::dm_cmd_entry_t)
    ) u_cmd_fifo (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .wr_i        (cmd_wr_i),
        .din_i       (cmd_entry_i),
        .full_o      (),
        .overflow_o  (overflow_o),
        .rd_i        (dm_cmd_valid_o && dm_cmd_ready_i),
        .dout_o      (head),
        .valid_o     (dm_cmd_valid_o),
        .underflow_o ()
    );

    // only the address and tag change between commands
    always_comb begin
        dm_cmd_o           = '0;
        dm_cmd_o.tag       = {3'b000, head.final_cmd};
        // bottom 10 address bits are always zero
        dm_cmd_o.addr      = {head.done_addr, head.kb_offset, 10'h000};
        dm_cmd_o.drr       = 1'b0;
        dm_cmd_o.eof       = 1'b1;
        dm_cmd_o.type_incr = 1'b1;
        dm_cmd_o.btt       = evreq_pkg::CHUNK_SIZE_BTT;
    end

endmodule

//--- req_gen/chunk_cmd_fsm.sv
`timescale 1ns/1ps
module chunk_cmd_fsm #(
    parameter logic [6:0] BASE_ADDRESS_4KB = 7'd4
) (
    input  logic                                 memclk,
    input  logic                                 memresetn,
    input  logic                                 payload_valid_i,
    input  evreq_pkg::payload_ident_t            payload_ident_i,
    input  logic                                 payload_last_i,
    input  logic                                 done_valid_i,
    input  logic [evreq_pkg::DONE_ADDR_W-1:0]    done_addr_i,
    output logic                                 payload_has_space_o,
    output logic                                 cmd_wr_o,
    output evreq_pkg::dm_cmd_entry_t             cmd_entry_o,
    output logic                                 final_wr_o
);
    localparam int KB_W = evreq_pkg::ADDR_KB_W;
    // base in kB, 4 kB units shifted up by two
    localparam logic [KB_W-1:0] BASE_KB = {BASE_ADDRESS_4KB, 2'b00};

    typedef enum logic [2:0] {
        IDLE,
        LOAD_BASE,
        WAIT_LAST,
        INCREMENT,
        WAIT_NEXT_CHUNK
    } state_t;

    state_t          state_q;
    logic [KB_W-1:0] offset_q;
    logic [KB_W-1:0] chunk_kb;
    logic [KB_W-1:0] addend_a;
    logic [KB_W-1:0] addend_b;
    logic            last_beat;
    logic            at_last_surf;
    logic            is_final;

    assign last_beat    = payload_valid_i && payload_last_i;
    assign at_last_surf = (payload_ident_i.surf == evreq_pkg::LAST_SURF);
    assign is_final     = at_last_surf && (payload_ident_i.chunk == evreq_pkg::LAST_CHUNK);

    ////////////////////////////////////////
    // address adder
    ////////////////////////////////////////

    // chunk start offset, chunk number x 4 kB
    assign chunk_kb = evreq_pkg::CHUNK_SIZE_KB * {{(KB_W - 2){1'b0}}, payload_ident_i.chunk};

    // one adder covers both load and increment
    always_comb begin
        addend_a = offset_q;
        addend_b = '0;
        if (state_q == LOAD_BASE) begin
            addend_a = BASE_KB + chunk_kb;
        end
        if (state_q == INCREMENT) begin
            addend_b = evreq_pkg::SURF_SIZE_KB;
        end
    end

    always_ff @(posedge memclk) begin
        if (state_q == LOAD_BASE || state_q == INCREMENT) begin
            offset_q <= addend_a + addend_b;
        end
    end

    ////////////////////////////////////////
    // chunk tracking FSM
    ////////////////////////////////////////

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (payload_valid_i && done_valid_i) begin
                        state_q <= LOAD_BASE;
                    end
                end
                LOAD_BASE: state_q <= WAIT_LAST;
                WAIT_LAST: begin
                    // idents run SURF 0..6 within a chunk, then the chunk steps
                    if (last_beat) begin
                        if (is_final) begin
                            state_q <= IDLE;
                        end else if (at_last_surf) begin
                            state_q <= WAIT_NEXT_CHUNK;
                        end else begin
                            state_q <= INCREMENT;
                        end
                    end
                end
                INCREMENT: state_q <= WAIT_LAST;
                WAIT_NEXT_CHUNK: begin
                    if (payload_valid_i) begin
                        state_q <= LOAD_BASE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // one entry per chunk, written at its last beat
    assign cmd_wr_o              = (state_q == WAIT_LAST) && last_beat;
    assign final_wr_o            = cmd_wr_o && is_final;
    assign cmd_entry_o.final_cmd = is_final;
    assign cmd_entry_o.done_addr = done_addr_i;
    assign cmd_entry_o.kb_offset = offset_q;

    // space when mid-event between chunks, or idle with an address waiting
    assign payload_has_space_o = (state_q == WAIT_NEXT_CHUNK) ||
                                 (state_q == IDLE && done_valid_i);

endmodule

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
module sync_fifo #(
    parameter int  DEPTH = 16,
    parameter type T     = logic [7:0]
) (
    input  logic memclk,
    input  logic memresetn,
    input  logic wr_i,
    input  T     din_i,
    output logic full_o,
    output logic overflow_o,
    input  logic rd_i,
    output T     dout_o,
    output logic valid_o,
    output logic underflow_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // register array storage
    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // writes when full are dropped, reads when empty are ignored
    assign do_wr = wr_i && !full_o;
    assign do_rd = rd_i && valid_o;

    assign full_o      = (count == CNT_W'(DEPTH));
    assign valid_o     = (count != '0);
    assign overflow_o  = wr_i && full_o;
    assign underflow_o = rd_i && !valid_o;

    // show-ahead output presents the head entry
    assign dout_o = mem[rd_ptr];

    always_ff @(posedge memclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- common/evreq_pkg.sv
package evreq_pkg;

    ////////////////////////////////////////
    // sizes and event layout
    ////////////////////////////////////////

    // kilobyte offset width, max offset is well under 512 kB
    localparam int ADDR_KB_W = 9;
    // done address is address[31:19]
    localparam int DONE_ADDR_W = 13;

    // one chunk is 2048 samples x 2 bytes = 4 kB
    localparam logic [ADDR_KB_W-1:0] CHUNK_SIZE_KB = 9'd4;
    // SURFs sit 4 chunks apart
    localparam logic [ADDR_KB_W-1:0] SURF_SIZE_KB = 9'd16;
    localparam logic [22:0] CHUNK_SIZE_BTT = 23'd4096;

    localparam logic [2:0] LAST_SURF = 3'd6;
    localparam logic [1:0] LAST_CHUNK = 2'd3;
    // 7 SURFs x 4 chunks
    localparam int NUM_SURF_XFERS = 28;

    ////////////////////////////////////////
    // packed types
    ////////////////////////////////////////

    typedef struct packed {
        logic [1:0] chunk;
        logic [2:0] surf;
    } payload_ident_t;

    // compact command, holds address[31:10] plus the final flag
    typedef struct packed {
        logic                   final_cmd;
        logic [DONE_ADDR_W-1:0] done_addr;
        logic [ADDR_KB_W-1:0]   kb_offset;
    } dm_cmd_entry_t;

    // DataMover S2MM command, no user/cache fields
    typedef struct packed {
        logic [3:0]  rsvd;
        logic [3:0]  tag;
        logic [31:0] addr;
        logic        drr;
        logic        eof;
        logic [5:0]  dsa;
        logic        type_incr;
        logic [22:0] btt;
    } dm_cmd_t;

    typedef struct packed {
        logic       okay;
        logic       slverr;
        logic       decerr;
        logic       interr;
        logic [3:0] tag;
    } dm_stat_t;

    typedef struct packed {
        logic [DONE_ADDR_W-1:0]    done_addr;
        logic                      err_last;
        logic [NUM_SURF_XFERS-2:0] err_hist;
        logic [3:0]                sticky_err;
    } cmpl_t;

    // bit 0 is the command overflow, bit 3 the done address underflow
    typedef struct packed {
        logic done_underflow;
        logic cmpl_overflow;
        logic done_overflow;
        logic cmd_overflow;
    } cmd_err_t;

endpackage
